// ==== vlog.f ====
+incdir+hdl
hdl/pic_types_pkg.sv
hdl/pic_regmap_pkg.sv
hdl/pic_gateway.sv
hdl/pic_regfile.sv
hdl/pic_arbiter.sv
hdl/pic_top.sv
verification/pic_tb_chk.sv
verification/pic_tb.sv

// ==== Bender.yml ====
package:
  name: pic

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/pic_types_pkg.sv
      - hdl/pic_regmap_pkg.sv
      - hdl/pic_gateway.sv
      - hdl/pic_regfile.sv
      - hdl/pic_arbiter.sv
      - hdl/pic_top.sv
  - target: test
    files:
      - verification/pic_tb_chk.sv
      - verification/pic_tb.sv

// ==== verification/pic_tb.sv ====
// Testbench of the interrupt controller
// Directed tests against a reference model, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

`include "pic_defines.svh"

module pic_tb
   import pic_types_pkg::*;
   import pic_regmap_pkg::*;
;

   localparam int CLK_NS    = 10;
   localparam int CLEAR_CYC = 300;   // Rewrite of all 31 sources
   localparam int RUN_CYC   = 8 + 250 + 4 * CLEAR_CYC + 150 + 1100 + 150 + 700;
   localparam int LIMIT_NS  = 2 * RUN_CYC * CLK_NS;

   logic      clk;
   logic      rst;
   src_vec_t  extintsrc_req;
   pic_addr_t picm_rdaddr;
   pic_addr_t picm_wraddr;
   pic_data_t picm_wr_data;
   logic      picm_wren;
   logic      picm_rden;
   prio_t     meicurpl;
   prio_t     meipt;
   pic_data_t picm_rd_data;
   logic      mexintpend;
   claim_id_t claimid;
   prio_t     pl;
   logic      mhwakeup;

   // Reference model state
   prio_t    m_prio [`PIC_NUM_SRC];
   logic     m_en   [`PIC_NUM_SRC];
   gw_cfg_t  m_cfg  [`PIC_NUM_SRC];
   logic     m_rev;
   src_vec_t raw_q;       // Last driven raw requests
   src_vec_t edge_pend;   // Expected edge latches
   int       checks;
   int       errors;

   pic_top uut (
      .clk           (clk),
      .rst           (rst),
      .extintsrc_req (extintsrc_req),
      .picm_rdaddr   (picm_rdaddr),
      .picm_wraddr   (picm_wraddr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .meicurpl      (meicurpl),
      .meipt         (meipt),
      .picm_rd_data  (picm_rd_data),
      .mexintpend    (mexintpend),
      .claimid       (claimid),
      .pl            (pl),
      .mhwakeup      (mhwakeup)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Bus access and model
   ////////////////////////////////////////
   function automatic pic_addr_t reg_addr(input pic_addr_t ofs, input int src);
      return `PIC_BASE_ADDR + ofs + pic_addr_t'(4 * src);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual == expected) else begin
         $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic bus_write(input pic_addr_t addr, input pic_data_t data);
      @(posedge clk);
      picm_wren    <= 1'b1;
      picm_wraddr  <= addr;
      picm_wr_data <= data;
      @(posedge clk);
      picm_wren <= 1'b0;
      @(posedge clk);   // Register takes the value at this edge
   endtask

   task automatic bus_read(input pic_addr_t addr, output pic_data_t data);
      @(posedge clk);
      picm_rden   <= 1'b1;
      picm_rdaddr <= addr;
      @(posedge clk);
      picm_rden <= 1'b0;
      @(negedge clk);
      data = picm_rd_data;
   endtask

   // Both strobes in the same cycle
   task automatic bus_write_read(input pic_addr_t addr, input pic_data_t wdata,
                                 output pic_data_t rdata);
      @(posedge clk);
      {picm_wren, picm_rden} <= 2'b11;
      picm_wraddr  <= addr;
      picm_rdaddr  <= addr;
      picm_wr_data <= wdata;
      @(posedge clk);
      {picm_wren, picm_rden} <= 2'b00;
      @(negedge clk);
      rdata = picm_rd_data;
   endtask

   task automatic set_source(input int src, input prio_t p, input logic en,
                             input gw_cfg_t cfg);
      bus_write(reg_addr(`PIC_PRIO_OFS, src), pic_data_t'(p));
      bus_write(reg_addr(`PIC_ENABLE_OFS, src), pic_data_t'(en));
      bus_write(reg_addr(`PIC_GWCFG_OFS, src), pic_data_t'(cfg));
      m_prio[src] = p;
      m_en[src]   = en;
      m_cfg[src]  = cfg;
   endtask

   task automatic clear_sources();
      for (int s = 1; s < `PIC_NUM_SRC; s++) begin
         set_source(s, 4'd0, 1'b0, 2'b00);
      end
      edge_pend = '0;
   endtask

   task automatic drive_requests(input src_vec_t v);
      @(posedge clk);
      extintsrc_req <= v;
      raw_q = v;
   endtask

   // Gateway outputs as the model sees them
   function automatic src_vec_t model_requests();
      src_vec_t req;
      logic     act;
      req = '0;
      for (int s = 1; s < `PIC_NUM_SRC; s++) begin
         act    = raw_q[s] ^ m_cfg[s][0];
         req[s] = m_cfg[s][1] ? (act | edge_pend[s]) : act;
      end
      return req;
   endfunction

   // Linear scan, strict compare keeps the lowest id on a tie
   task automatic check_outputs(input string name, input int cycles);
      src_vec_t req;
      int       eff;
      int       best;
      int       win;
      int       lvl;
      int       ipt;
      int       cur;
      repeat (cycles) @(posedge clk);
      @(negedge clk);
      req  = model_requests();
      best = 0;
      win  = 0;
      for (int s = 1; s < `PIC_NUM_SRC; s++) begin
         eff = m_rev ? 15 - int'(m_prio[s]) : int'(m_prio[s]);
         if (req[s] && m_en[s] && eff > best) begin
            best = eff;
            win  = s;
         end
      end
      lvl = m_rev ? 15 - best : best;
      ipt = m_rev ? 15 - int'(meipt) : int'(meipt);
      cur = m_rev ? 15 - int'(meicurpl) : int'(meicurpl);
      check_value({name, " claimid"}, win, claimid);
      check_value({name, " pl"}, lvl, pl);
      check_value({name, " mexintpend"}, (best > ipt) && (best > cur), mexintpend);
      check_value({name, " mhwakeup"}, lvl == (m_rev ? 0 : 15), mhwakeup);
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic test_regs();
      int        src [6];
      pic_data_t rd;
      pic_data_t wd;
      for (int i = 0; i < 6; i++) begin
         src[i] = 1 + $urandom % 31;
         set_source(src[i], prio_t'($urandom), 1'($urandom), gw_cfg_t'($urandom));
      end
      for (int i = 0; i < 6; i++) begin
         bus_read(reg_addr(`PIC_PRIO_OFS, src[i]), rd);
         check_value("test_regs prio", m_prio[src[i]], rd);
         bus_read(reg_addr(`PIC_ENABLE_OFS, src[i]), rd);
         check_value("test_regs enable", m_en[src[i]], rd);
         bus_read(reg_addr(`PIC_GWCFG_OFS, src[i]), rd);
         check_value("test_regs gwcfg", m_cfg[src[i]], rd);
      end
      bus_write(reg_addr(`PIC_CONFIG_OFS, 0), 32'h1);
      bus_read(reg_addr(`PIC_CONFIG_OFS, 0), rd);
      check_value("test_regs config set", 1, rd);
      bus_write(reg_addr(`PIC_CONFIG_OFS, 0), 32'h0);
      bus_read(reg_addr(`PIC_CONFIG_OFS, 0), rd);
      check_value("test_regs config clear", 0, rd);
      bus_write(reg_addr(`PIC_PRIO_OFS, 0), 32'hf);   // Slot 0 stays zero
      bus_read(reg_addr(`PIC_PRIO_OFS, 0), rd);
      check_value("test_regs slot 0", 0, rd);
      wd = $urandom;
      bus_write_read(reg_addr(`PIC_PRIO_OFS, src[0]), wd, rd);
      check_value("test_regs bypass", wd, rd);
      m_prio[src[0]] = wd[3:0];
   endtask

   task automatic test_arbitration();
      src_vec_t v;
      int       s;
      int       lo;
      int       hi;
      clear_sources();
      v = '0;
      for (int i = 0; i < 4; i++) begin
         s = 1 + $urandom % 31;
         set_source(s, prio_t'(1 + $urandom % 14), 1'b1, 2'b00);
         v[s] = 1'b1;
      end
      drive_requests(v);
      check_outputs("test_arbitration random", 3);
      lo = 1 + $urandom % 15;
      hi = lo + 1 + $urandom % 15;
      set_source(lo, 4'd15, 1'b1, 2'b00);
      set_source(hi, 4'd15, 1'b1, 2'b00);
      v[lo] = 1'b1;
      v[hi] = 1'b1;
      drive_requests(v);
      check_outputs("test_arbitration tie", 3);
      check_value("test_arbitration tie winner", lo, claimid);
      set_source(lo, 4'd15, 1'b0, 2'b00);
      check_outputs("test_arbitration disabled", 1);
      check_value("test_arbitration disabled winner", hi, claimid);
   endtask

   task automatic test_threshold();
      int s;
      clear_sources();
      s = 1 + $urandom % 31;
      drive_requests(src_vec_t'(1) << s);
      for (int k = 0; k < 2; k++) begin
         set_source(s, (k == 0) ? prio_t'(1 + $urandom % 14) : 4'd15, 1'b1, 2'b00);
         for (int t = 0; t < 256; t++) begin
            @(posedge clk);
            meipt    <= prio_t'(t);
            meicurpl <= prio_t'(t >> 4);
            check_outputs("test_threshold", 1);
         end
      end
      @(posedge clk);
      meipt    <= '0;
      meicurpl <= '0;
   endtask

   task automatic test_gateway();
      int        a;
      int        b;
      pic_data_t rd;
      clear_sources();
      a = 1 + $urandom % 15;
      b = 16 + $urandom % 15;
      set_source(a, 4'd7, 1'b1, 2'b01);   // Level, active low
      check_outputs("test_gateway active low", 3);
      drive_requests(src_vec_t'(1) << a);
      check_outputs("test_gateway active low idle", 3);
      set_source(b, 4'd9, 1'b1, 2'b10);   // Edge, active high
      @(posedge clk);
      extintsrc_req <= raw_q | (src_vec_t'(1) << b);
      @(posedge clk);
      extintsrc_req <= raw_q;
      edge_pend[b] = 1'b1;
      check_outputs("test_gateway edge held", 4);
      bus_read(reg_addr(`PIC_PEND_OFS, 0), rd);
      check_value("test_gateway pending set", model_requests(), rd);
      bus_write(reg_addr(`PIC_GWCLR_OFS, b), 32'h0);
      edge_pend[b] = 1'b0;
      check_outputs("test_gateway edge cleared", 1);
      bus_read(reg_addr(`PIC_PEND_OFS, 0), rd);
      check_value("test_gateway pending clear", model_requests(), rd);
      drive_requests('0);
   endtask

   task automatic test_reverse_order();
      src_vec_t v;
      int       s;
      clear_sources();
      bus_write(reg_addr(`PIC_CONFIG_OFS, 0), 32'h1);
      m_rev = 1'b1;
      v     = '0;
      for (int i = 0; i < 3; i++) begin
         s = 1 + $urandom % 31;
         set_source(s, prio_t'(1 + $urandom % 14), 1'b1, 2'b00);
         v[s] = 1'b1;
      end
      drive_requests(v);
      check_outputs("test_reverse_order lowest wins", 3);
      for (int t = 0; t < 256; t++) begin
         @(posedge clk);
         meipt    <= prio_t'(t);
         meicurpl <= prio_t'(t >> 4);
         check_outputs("test_reverse_order threshold", 1);
      end
      s = 1 + $urandom % 31;
      set_source(s, 4'd0, 1'b1, 2'b00);   // Top level when reversed
      v[s] = 1'b1;
      drive_requests(v);
      check_outputs("test_reverse_order wake", 3);
      check_value("test_reverse_order wake flag", 1, mhwakeup);
      bus_write(reg_addr(`PIC_CONFIG_OFS, 0), 32'h0);
      m_rev = 1'b0;
      @(posedge clk);
      meipt    <= '0;
      meicurpl <= '0;
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////
   initial begin
      void'($urandom(32'h309bd128));
      rst           <= 1'b1;
      extintsrc_req <= '0;
      picm_rdaddr   <= '0;
      picm_wraddr   <= '0;
      picm_wr_data  <= '0;
      picm_wren     <= 1'b0;
      picm_rden     <= 1'b0;
      meicurpl      <= '0;
      meipt         <= '0;
      raw_q     = '0;
      edge_pend = '0;
      m_rev     = 1'b0;
      checks    = 0;
      errors    = 0;
      for (int s = 0; s < `PIC_NUM_SRC; s++) begin
         m_prio[s] = '0;
         m_en[s]   = 1'b0;
         m_cfg[s]  = '0;
      end
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      test_regs();
      test_arbitration();
      test_threshold();
      test_gateway();
      test_reverse_order();
      repeat (2) @(posedge clk);
      errors += uut.u_chk.fail_count;   // Bound assertion failures
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(LIMIT_NS);
      $display("Timeout: tests did not finish within %0d ns", LIMIT_NS);
      $display("TB FAILED");
      $finish;
   end

endmodule : pic_tb

`default_nettype wire

// ==== verification/pic_tb_chk.sv ====
// Concurrent checks on the controller outputs and read port
// Bound into pic_top
`timescale 1ns/1ps
`default_nettype none

module pic_tb_chk
   import pic_types_pkg::*;
(
   input wire            clk,
   input wire            rst,
   input wire            picm_rden,
   input wire [31:0]     picm_rd_data,
   input wire            mexintpend,
   input wire claim_id_t claimid,
   input wire prio_t     pl,
   input wire            mhwakeup
);

   int fail_count = 0;

   // Every output cleared by a reset edge
   reset_outputs_zero: assert property (@(posedge clk)
      rst |=> (claimid == '0 && pl == '0 && !mexintpend && !mhwakeup && picm_rd_data == '0))
   else begin
      $error("Outputs not zero while reset is high");
      fail_count++;
   end

   // Read data only in the cycle after a captured read
   rd_data_idle: assert property (@(posedge clk) disable iff (rst)
      !$past(picm_rden) |-> picm_rd_data == '0)
   else begin
      $error("Read data not zero without a captured read");
      fail_count++;
   end

   claim_in_range: assert property (@(posedge clk) disable iff (rst) claimid <= 8'd31)
   else begin
      $error("Claim id above the last source");
      fail_count++;
   end

endmodule : pic_tb_chk

bind pic_top pic_tb_chk u_chk (
   .clk          (clk),
   .rst          (rst),
   .picm_rden    (picm_rden),
   .picm_rd_data (picm_rd_data),
   .mexintpend   (mexintpend),
   .claimid      (claimid),
   .pl           (pl),
   .mhwakeup     (mhwakeup)
);

`default_nettype wire

// ==== hdl/pic_top.sv ====
// Top level of the interrupt controller
// Register file, one gateway per source and the arbiter
`timescale 1ns/1ps
`default_nettype none

`include "pic_defines.svh"

module pic_top
   import pic_types_pkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire src_vec_t extintsrc_req,   // Bit 0 is reserved
   input  wire [31:0]    picm_rdaddr,
   input  wire [31:0]    picm_wraddr,
   input  wire [31:0]    picm_wr_data,
   input  wire           picm_wren,
   input  wire           picm_rden,
   input  wire prio_t    meicurpl,
   input  wire prio_t    meipt,
   output logic [31:0]   picm_rd_data,
   output logic          mexintpend,
   output claim_id_t     claimid,
   output prio_t         pl,
   output logic          mhwakeup
);

   prio_vec_t                  prio;
   src_vec_t                   enable;
   gw_cfg_t [`PIC_NUM_SRC-1:0] gw_cfg;
   src_vec_t                   gw_clear;
   src_vec_t                   gw_req;
   logic                       rev_order;

   pic_regfile u_regfile (
      .clk          (clk),
      .rst          (rst),
      .picm_rdaddr  (picm_rdaddr),
      .picm_wraddr  (picm_wraddr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .gw_req       (gw_req),
      .picm_rd_data (picm_rd_data),
      .prio         (prio),
      .enable       (enable),
      .gw_cfg       (gw_cfg),
      .gw_clear     (gw_clear),
      .rev_order    (rev_order)
   );

   assign gw_req[0] = 1'b0;   // Source 0 never requests

   for (genvar s = 1; s < `PIC_NUM_SRC; s++) begin : g_gw
      pic_gateway u_gw (
         .clk     (clk),
         .rst     (rst),
         .raw_req (extintsrc_req[s]),
         .cfg     (gw_cfg[s]),
         .clear   (gw_clear[s]),
         .req     (gw_req[s])
      );
   end

   pic_arbiter u_arbiter (
      .clk        (clk),
      .rst        (rst),
      .req        (gw_req),
      .enable     (enable),
      .prio       (prio),
      .rev_order  (rev_order),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule : pic_top

`default_nettype wire

// ==== hdl/pic_arbiter.sv ====
// Interrupt arbiter with priority order adjustment and comparator tree
// Registered claim id, level, pending and wake-up outputs
`timescale 1ns/1ps
`default_nettype none

`include "pic_defines.svh"

module pic_arbiter
   import pic_types_pkg::*;
(
   input  wire            clk,
   input  wire            rst,
   input  wire src_vec_t  req,
   input  wire src_vec_t  enable,
   input  wire prio_vec_t prio,
   input  wire            rev_order,
   input  wire prio_t     meipt,       // Priority threshold
   input  wire prio_t     meicurpl,    // Current priority level
   output claim_id_t      claimid,
   output prio_t          pl,
   output logic           mexintpend,
   output logic           mhwakeup
);

   // Tree nodes in heap order, root at 0 and leaves at the end
   localparam int FIRST_LEAF = `PIC_NUM_SRC - 1;
   localparam int NUM_NODES  = 2 * `PIC_NUM_SRC - 1;

   prio_vec_t eff_prio;
   prio_t     node_prio [NUM_NODES];
   claim_id_t node_id   [NUM_NODES];
   prio_t     pl_next;
   prio_t     meipt_adj;
   prio_t     meicurpl_adj;
   prio_t     max_level;
   logic      pend_next;
   logic      wake_next;

   // Effective priority, zero unless requesting and enabled
   always_comb begin
      for (int s = 0; s < `PIC_NUM_SRC; s++) begin
         if (req[s] && enable[s]) begin
            eff_prio[s] = rev_order ? ~prio[s] : prio[s];
         end else begin
            eff_prio[s] = '0;
         end
      end
   end

   ////////////////////////////////////////
   // Comparator tree
   ////////////////////////////////////////
   for (genvar s = 0; s < `PIC_NUM_SRC; s++) begin : g_leaf
      assign node_prio[FIRST_LEAF+s] = eff_prio[s];
      assign node_id[FIRST_LEAF+s]   = claim_id_t'(s);
   end

   // Five levels of compare and select
   // The left child holds the lower ids and wins a tie
   for (genvar k = 0; k < FIRST_LEAF; k++) begin : g_cmp
      logic right_wins;

      assign right_wins   = node_prio[2*k+2] > node_prio[2*k+1];
      assign node_prio[k] = right_wins ? node_prio[2*k+2] : node_prio[2*k+1];
      assign node_id[k]   = right_wins ? node_id[2*k+2]   : node_id[2*k+1];
   end

   ////////////////////////////////////////
   // Claim and threshold stage
   ////////////////////////////////////////
   assign pl_next      = rev_order ? ~node_prio[0] : node_prio[0];   // Back to raw value
   assign meipt_adj    = rev_order ? ~meipt : meipt;
   assign meicurpl_adj = rev_order ? ~meicurpl : meicurpl;

   assign pend_next = (node_prio[0] > meipt_adj) & (node_prio[0] > meicurpl_adj);

   assign max_level = rev_order ? '0 : '1;
   assign wake_next = (pl_next == max_level);

   always_ff @(posedge clk) begin
      if (rst) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= node_id[0];
         pl         <= pl_next;
         mexintpend <= pend_next;
         mhwakeup   <= wake_next;
      end
   end

endmodule : pic_arbiter

`default_nettype wire

// ==== hdl/pic_regfile.sv ====
// Register file of the interrupt controller
// Port capture, address decode, config registers, read mux and bypass
`timescale 1ns/1ps
`default_nettype none

`include "pic_defines.svh"

module pic_regfile
   import pic_types_pkg::*;
   import pic_regmap_pkg::*;
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire pic_addr_t             picm_rdaddr,
   input  wire pic_addr_t             picm_wraddr,
   input  wire pic_data_t             picm_wr_data,
   input  wire                        picm_wren,
   input  wire                        picm_rden,
   input  wire src_vec_t              gw_req,
   output pic_data_t                  picm_rd_data,
   output prio_vec_t                  prio,
   output src_vec_t                   enable,
   output gw_cfg_t [`PIC_NUM_SRC-1:0] gw_cfg,
   output src_vec_t                   gw_clear,
   output logic                       rev_order
);

   // Lowest address bit above the source index
   localparam int BLK_LSB = `PIC_IDX_BITS + 2;

   localparam pic_addr_t PRIO_BASE   = `PIC_BASE_ADDR + `PIC_PRIO_OFS;
   localparam pic_addr_t PEND_BASE   = `PIC_BASE_ADDR + `PIC_PEND_OFS;
   localparam pic_addr_t ENABLE_BASE = `PIC_BASE_ADDR + `PIC_ENABLE_OFS;
   localparam pic_addr_t CONFIG_BASE = `PIC_BASE_ADDR + `PIC_CONFIG_OFS;
   localparam pic_addr_t GWCFG_BASE  = `PIC_BASE_ADDR + `PIC_GWCFG_OFS;
   localparam pic_addr_t GWCLR_BASE  = `PIC_BASE_ADDR + `PIC_GWCLR_OFS;

   pic_addr_t   rdaddr_q;
   pic_addr_t   wraddr_q;
   pic_data_t   wr_data_q;
   logic        wren_q;
   logic        rden_q;
   reg_region_e r_region;
   reg_region_e w_region;
   reg_idx_t    r_idx;
   reg_idx_t    w_idx;
   logic        slot_we;
   logic        bypass;
   pic_data_t   rd_mux;

   function automatic reg_region_e decode_region(input pic_addr_t addr);
      reg_region_e region;
      case (addr[31:BLK_LSB])
         PRIO_BASE[31:BLK_LSB]:   region = REG_PRIO;
         ENABLE_BASE[31:BLK_LSB]: region = REG_ENABLE;
         GWCFG_BASE[31:BLK_LSB]:  region = REG_GWCFG;
         GWCLR_BASE[31:BLK_LSB]:  region = REG_GWCLR;
         default:                 region = REG_NONE;
      endcase
      // Pending and config are single words
      if (addr == PEND_BASE) begin
         region = REG_PEND;
      end
      if (addr == CONFIG_BASE) begin
         region = REG_CONFIG;
      end
      return region;
   endfunction

   ////////////////////////////////////////
   // Port capture
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= picm_wren;
         rden_q <= picm_rden;
      end
   end

   always_ff @(posedge clk) begin
      rdaddr_q  <= picm_rdaddr;
      wraddr_q  <= picm_wraddr;
      wr_data_q <= picm_wr_data;
   end

   assign r_region = decode_region(rdaddr_q);
   assign w_region = decode_region(wraddr_q);
   assign r_idx    = rdaddr_q[BLK_LSB-1:2];
   assign w_idx    = wraddr_q[BLK_LSB-1:2];
   assign slot_we  = wren_q & (w_idx != '0);   // Slot 0 never written

   ////////////////////////////////////////
   // Configuration registers
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         prio      <= '0;
         enable    <= '0;
         gw_cfg    <= '0;
         rev_order <= 1'b0;
      end else begin
         if (slot_we && w_region == REG_PRIO) begin
            prio[w_idx] <= wr_data_q[`PIC_PRIO_BITS-1:0];
         end
         if (slot_we && w_region == REG_ENABLE) begin
            enable[w_idx] <= wr_data_q[0];
         end
         if (slot_we && w_region == REG_GWCFG) begin
            gw_cfg[w_idx] <= wr_data_q[1:0];
         end
         if (wren_q && w_region == REG_CONFIG) begin
            rev_order <= wr_data_q[0];   // Reverse priority order
         end
      end
   end

   // Clear strobe during the cycle after capture
   always_comb begin
      gw_clear = '0;
      if (slot_we && w_region == REG_GWCLR) begin
         gw_clear[w_idx] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////
   always_comb begin
      rd_mux = '0;
      if (rden_q) begin
         case (r_region)
            REG_PRIO:   rd_mux = pic_data_t'(prio[r_idx]);
            REG_PEND:   rd_mux = pic_data_t'(gw_req);
            REG_ENABLE: rd_mux = pic_data_t'(enable[r_idx]);
            REG_CONFIG: rd_mux = pic_data_t'(rev_order);
            REG_GWCFG:  rd_mux = pic_data_t'(gw_cfg[r_idx]);
            default:    rd_mux = '0;   // Clear strobe reads zero
         endcase
      end
   end

   // Same-address read and write return the write data
   assign bypass       = rden_q & wren_q & (rdaddr_q == wraddr_q);
   assign picm_rd_data = bypass ? wr_data_q : rd_mux;

endmodule : pic_regfile

`default_nettype wire

// ==== hdl/pic_gateway.sv ====
// Interrupt gateway for one source
// Two-flop synchronizer, polarity and edge latch
`timescale 1ns/1ps
`default_nettype none

module pic_gateway
   import pic_types_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire          raw_req,
   input  wire gw_cfg_t cfg,
   input  wire          clear,     // One-cycle clear of the edge latch
   output logic         req
);

   logic sync_meta;   // First synchronizer stage
   logic sync_req;
   logic active;
   logic pend;

   always_ff @(posedge clk) begin
      if (rst) begin
         sync_meta <= 1'b0;
         sync_req  <= 1'b0;
      end else begin
         sync_meta <= raw_req;
         sync_req  <= sync_meta;
      end
   end

   assign active = sync_req ^ cfg[0];

   // Edge latch, only armed in edge mode
   always_ff @(posedge clk) begin
      if (rst) begin
         pend <= 1'b0;
      end else begin
         pend <= cfg[1] & (active | (pend & ~clear));
      end
   end

   assign req = cfg[1] ? (active | pend) : active;

endmodule : pic_gateway

`default_nettype wire

// ==== hdl/pic_regmap_pkg.sv ====
// Register map types, region decode enum and address fields
`default_nettype none

`include "pic_defines.svh"

package pic_regmap_pkg;

   typedef logic [31:0] pic_addr_t;   // Bus address
   typedef logic [31:0] pic_data_t;   // Bus data word

   // Source index taken from address bits above the byte offset
   typedef logic [`PIC_IDX_BITS-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      REG_NONE,
      REG_PRIO,
      REG_PEND,
      REG_ENABLE,
      REG_CONFIG,
      REG_GWCFG,
      REG_GWCLR
   } reg_region_e;

endpackage : pic_regmap_pkg

`default_nettype wire

// ==== hdl/pic_types_pkg.sv ====
// Types of the interrupt request and arbitration path
`default_nettype none

`include "pic_defines.svh"

package pic_types_pkg;

   typedef logic [`PIC_PRIO_BITS-1:0] prio_t;      // Priority or threshold
   typedef logic [`PIC_ID_BITS-1:0]   claim_id_t;  // Source number

   // One bit per source slot
   typedef logic [`PIC_NUM_SRC-1:0] src_vec_t;

   // Priority of every source slot
   typedef prio_t [`PIC_NUM_SRC-1:0] prio_vec_t;

   // Gateway config
   // Bit 0 polarity, 1 is active low
   // Bit 1 type, 1 is edge
   typedef logic [1:0] gw_cfg_t;

endpackage : pic_types_pkg

`default_nettype wire

// ==== hdl/pic_defines.svh ====
// Source count, field widths and register map of the interrupt controller
// Every region sits at base + offset + 4 x source

`ifndef PIC_DEFINES_SVH
`define PIC_DEFINES_SVH

// Source slots, slot 0 reserved
`define PIC_NUM_SRC     32
`define PIC_PRIO_BITS   4
`define PIC_ID_BITS     8
`define PIC_IDX_BITS    5              // Source index field of an address

`define PIC_BASE_ADDR   32'hf00c_0000

// Region offsets
`define PIC_PRIO_OFS    32'h0000_0000  // Per-source priority
`define PIC_PEND_OFS    32'h0000_1000  // Pending vector, single word
`define PIC_ENABLE_OFS  32'h0000_2000  // Per-source enable
`define PIC_CONFIG_OFS  32'h0000_3000  // Global config, single word
`define PIC_GWCFG_OFS   32'h0000_4000  // Gateway polarity and type
`define PIC_GWCLR_OFS   32'h0000_5000  // Gateway clear strobe

`endif
